// File: verilog/eth_mac_params.svh
`ifndef ETH_MAC_PARAMS_SVH
`define ETH_MAC_PARAMS_SVH

// packet store geometry
`define ETH_PACKET_SIZE   402
`define ETH_RING_DEPTH    32
`define ETH_ADDR_W        9

// framing
`define ETH_PREAMBLE_BYTE 8'h55
`define ETH_SFD_BYTE      8'hd5
`define ETH_IFG_CYCLES    12
`define ETH_CRC_RESIDUE   32'hC704DD7B   // crc register after a good frame and its fcs

`endif

// File: verilog/eth_mac_pkg.sv
`default_nettype none

`include "eth_mac_params.svh"

package eth_mac_pkg;

	localparam logic [31:0] CRC_POLY = 32'h04C11DB7;   // ieee 802.3

	typedef enum logic [2:0] {
		OP_READ       = 3'd0,
		OP_READ_LEN   = 3'd1,
		OP_READ_NEXT  = 3'd2,
		OP_WRITE      = 3'd3,
		OP_WRITE_LEN  = 3'd4,
		OP_WRITE_NEXT = 3'd5
	} host_op_e;

	// ----------------------------------------
	// host return word, one of three views
	typedef struct packed {
		logic [7:0] pad;
		logic [7:0] data;
	} result_byte_t;

	typedef struct packed {
		logic [15-`ETH_ADDR_W:0] pad;
		logic [`ETH_ADDR_W-1:0]  len;
	} result_len_t;

	typedef struct packed {
		logic [14:0] pad;
		logic        flag;
	} result_flag_t;

	typedef union packed {
		result_byte_t as_byte;
		result_len_t  as_len;
		result_flag_t as_flag;
	} host_result_u;

	// one byte into the crc, bit 0 goes first on the wire
	function automatic logic [31:0] crc32_step(input logic [31:0] crc, input logic [7:0] data);
		logic [31:0] c;
		logic        fb;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			fb = c[31] ^ data[i];
			c = {c[30:0], 1'b0};
			if (fb)
				c = c ^ CRC_POLY;
		end
		return c;
	endfunction

endpackage

`default_nettype wire

// File: verilog/ring_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_mac_params.svh"

interface ring_if;

	// writer side
	logic                   wr_en;
	logic [`ETH_ADDR_W-1:0] wr_addr;
	logic [7:0]             wr_data;
	logic                   commit;
	logic                   trim;
	logic                   clear;     // restart the writer slot at length 0
	logic [`ETH_ADDR_W-1:0] wr_len;
	logic                   full;

	// reader side
	logic [`ETH_ADDR_W-1:0] rd_addr;
	logic [7:0]             rd_data;   // one cycle after rd_addr
	logic [`ETH_ADDR_W-1:0] rd_len;
	logic                   rd_release;
	logic                   empty;

	modport writer (output wr_en, wr_addr, wr_data, commit, trim, clear, input wr_len, full);
	modport reader (output rd_addr, rd_release, input rd_data, rd_len, empty);

	// mirrored views for the ring itself
	modport store_wr (input wr_en, wr_addr, wr_data, commit, trim, clear, output wr_len, full);
	modport store_rd (input rd_addr, rd_release, output rd_data, rd_len, empty);

endinterface

`default_nettype wire

// File: verilog/packet_ring.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_mac_params.svh"

module packet_ring (
	input wire logic clock_i,
	input wire logic reset_i,
	ring_if.store_wr wr,
	ring_if.store_rd rd
);

	localparam int PTR_W = $clog2(`ETH_RING_DEPTH);
	localparam logic [`ETH_ADDR_W-1:0] PKT_SIZE = `ETH_PACKET_SIZE;

	logic [7:0]             mem_q [`ETH_RING_DEPTH][`ETH_PACKET_SIZE];
	logic [`ETH_ADDR_W-1:0] len_q [`ETH_RING_DEPTH];
	logic [PTR_W-1:0]       wr_ptr_q;
	logic [PTR_W-1:0]       rd_ptr_q;
	logic [PTR_W-1:0]       wr_ptr_next;
	logic [`ETH_ADDR_W-1:0] cur_len;
	logic                   wr_ok;

	assign wr_ptr_next = wr_ptr_q + PTR_W'(1);   // depth is a power of two
	assign cur_len     = len_q[wr_ptr_q];
	assign wr_ok       = wr.wr_en && (wr.wr_addr < PKT_SIZE);

	assign wr.wr_len = cur_len;
	assign wr.full   = (wr_ptr_next == rd_ptr_q);
	assign rd.rd_len = len_q[rd_ptr_q];
	assign rd.empty  = (rd_ptr_q == wr_ptr_q);

	// ----------------------------------------
	// byte store
	always_ff @(posedge clock_i) begin
		if (wr_ok)
			mem_q[wr_ptr_q][wr.wr_addr] <= wr.wr_data;
		if (rd.rd_addr < len_q[rd_ptr_q])
			rd.rd_data <= mem_q[rd_ptr_q][rd.rd_addr];
		else
			rd.rd_data <= 8'd0;   // past the end
	end

	// ----------------------------------------
	// pointers and slot lengths
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			for (int i = 0; i < `ETH_RING_DEPTH; i++)
				len_q[i] <= '0;
		end else begin
			if (wr.clear)
				len_q[wr_ptr_q] <= '0;
			else if (wr.trim)
				len_q[wr_ptr_q] <= (cur_len >= `ETH_ADDR_W'(4)) ? cur_len - `ETH_ADDR_W'(4) : '0;
			else if (wr_ok && wr.wr_addr >= cur_len)
				len_q[wr_ptr_q] <= wr.wr_addr + `ETH_ADDR_W'(1);

			if (wr.commit && !wr.full && cur_len != '0) begin
				wr_ptr_q           <= wr_ptr_next;
				len_q[wr_ptr_next] <= '0;   // fresh slot
			end

			if (rd.rd_release && !rd.empty)
				rd_ptr_q <= rd_ptr_q + PTR_W'(1);
		end
	end

endmodule

`default_nettype wire

// File: verilog/gmii_tx_framer.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_mac_params.svh"

module gmii_tx_framer (
	input wire logic   clock_i,
	input wire logic   reset_i,
	ring_if.reader     ring,
	output logic [7:0] gmii_txd_o,
	output logic       gmii_tx_en_o,
	output logic       gmii_tx_er_o
);

	typedef enum logic [3:0] {
		ST_READY,
		ST_PREAMBLE,
		ST_SFD,
		ST_DATA,
		ST_FCS3,
		ST_FCS2,
		ST_FCS1,
		ST_FCS0,
		ST_GAP
	} state_e;

	state_e                 state_q;
	logic [3:0]             cnt_q;    // preamble and gap count
	logic [`ETH_ADDR_W-1:0] addr_q;   // next byte to fetch
	logic [`ETH_ADDR_W-1:0] len_q;
	logic [31:0]            crc_q;
	logic [7:0]             fcs_byte;

	function automatic logic [7:0] bit_reverse(input logic [7:0] b);
		logic [7:0] r;
		for (int i = 0; i < 8; i++)
			r[i] = b[7-i];
		return r;
	endfunction

	always_comb begin
		case (state_q)
			ST_FCS3: fcs_byte = crc_q[31:24];
			ST_FCS2: fcs_byte = crc_q[23:16];
			ST_FCS1: fcs_byte = crc_q[15:8];
			default: fcs_byte = crc_q[7:0];
		endcase
	end

	assign ring.rd_addr    = addr_q;   // one ahead of the byte on the wire
	assign ring.rd_release = (state_q == ST_GAP) && (cnt_q == 4'(`ETH_IFG_CYCLES - 1));
	assign gmii_tx_er_o    = 1'b0;

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			state_q      <= ST_READY;
			cnt_q        <= '0;
			addr_q       <= '0;
			gmii_txd_o   <= 8'd0;
			gmii_tx_en_o <= 1'b0;
		end else begin
			case (state_q)
				ST_READY: begin
					gmii_tx_en_o <= 1'b0;
					gmii_txd_o   <= 8'd0;
					addr_q       <= '0;
					cnt_q        <= '0;
					crc_q        <= '0;
					if (!ring.empty) begin
						len_q   <= ring.rd_len;
						state_q <= ST_PREAMBLE;
					end
				end
				ST_PREAMBLE: begin
					gmii_tx_en_o <= 1'b1;
					gmii_txd_o   <= `ETH_PREAMBLE_BYTE;
					if (cnt_q == 4'd6) begin
						cnt_q   <= '0;
						state_q <= ST_SFD;
					end else begin
						cnt_q <= cnt_q + 4'd1;
					end
				end
				ST_SFD: begin
					gmii_txd_o <= `ETH_SFD_BYTE;
					addr_q     <= addr_q + `ETH_ADDR_W'(1);   // byte 0 already fetched
					state_q    <= ST_DATA;
				end
				ST_DATA: begin
					gmii_txd_o <= ring.rd_data;
					crc_q      <= eth_mac_pkg::crc32_step(crc_q, ring.rd_data);
					if (addr_q == len_q)
						state_q <= ST_FCS3;
					else
						addr_q <= addr_q + `ETH_ADDR_W'(1);
				end
				ST_FCS3, ST_FCS2, ST_FCS1: begin
					gmii_txd_o <= ~bit_reverse(fcs_byte);
					state_q    <= state_e'(state_q + 4'd1);
				end
				ST_FCS0: begin
					gmii_txd_o <= ~bit_reverse(fcs_byte);
					cnt_q      <= '0;
					state_q    <= ST_GAP;
				end
				ST_GAP: begin
					gmii_tx_en_o <= 1'b0;
					gmii_txd_o   <= 8'd0;
					if (cnt_q == 4'(`ETH_IFG_CYCLES - 1))
						state_q <= ST_READY;   // slot freed this cycle
					else
						cnt_q <= cnt_q + 4'd1;
				end
				default: state_q <= ST_READY;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/gmii_rx_deframer.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_mac_params.svh"

module gmii_rx_deframer (
	input wire logic       clock_i,
	input wire logic       reset_i,
	input wire logic [7:0] gmii_rxd_i,
	input wire logic       gmii_rx_dv_i,
	input wire logic       gmii_rx_er_i,
	ring_if.writer         ring
);

	localparam logic [`ETH_ADDR_W-1:0] PKT_SIZE = `ETH_PACKET_SIZE;

	typedef enum logic [1:0] {
		ST_HUNT,
		ST_SFD,
		ST_DATA,
		ST_COMMIT
	} state_e;

	state_e                 state_q;
	logic [2:0]             pre_cnt_q;
	logic [`ETH_ADDR_W-1:0] addr_q;
	logic [31:0]            crc_q;
	logic                   rx_ok;
	logic                   residue_hit;
	logic                   in_range;
	logic                   sfd_seen;

	assign rx_ok       = gmii_rx_dv_i && !gmii_rx_er_i;
	assign residue_hit = (crc_q == `ETH_CRC_RESIDUE);
	assign in_range    = (addr_q < PKT_SIZE);
	assign sfd_seen    = (state_q == ST_SFD) && rx_ok && (gmii_rxd_i == `ETH_SFD_BYTE);

	assign ring.wr_en   = (state_q == ST_DATA) && rx_ok && !residue_hit && in_range;
	assign ring.wr_addr = addr_q;
	assign ring.wr_data = gmii_rxd_i;
	assign ring.clear   = sfd_seen && !ring.full;   // drops any stale partial frame
	assign ring.trim    = (state_q == ST_DATA) && residue_hit;   // strip the fcs
	assign ring.commit  = (state_q == ST_COMMIT);

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			state_q   <= ST_HUNT;
			pre_cnt_q <= '0;
			addr_q    <= '0;
		end else begin
			case (state_q)
				ST_HUNT: begin
					if (rx_ok && gmii_rxd_i == `ETH_PREAMBLE_BYTE) begin
						if (pre_cnt_q == 3'd6) begin
							pre_cnt_q <= '0;
							state_q   <= ST_SFD;
						end else begin
							pre_cnt_q <= pre_cnt_q + 3'd1;
						end
					end else begin
						pre_cnt_q <= '0;
					end
				end
				ST_SFD: begin
					if (sfd_seen && !ring.full) begin
						addr_q  <= '0;
						crc_q   <= '0;
						state_q <= ST_DATA;
					end else begin
						state_q <= ST_HUNT;   // no room or bad delimiter
					end
				end
				ST_DATA: begin
					if (residue_hit) begin
						state_q <= ST_COMMIT;
					end else if (!rx_ok || !in_range) begin
						state_q <= ST_HUNT;   // abandon
					end else begin
						addr_q <= addr_q + `ETH_ADDR_W'(1);
						crc_q  <= eth_mac_pkg::crc32_step(crc_q, gmii_rxd_i);
					end
				end
				ST_COMMIT: state_q <= ST_HUNT;
				default:   state_q <= ST_HUNT;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/host_access.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_mac_params.svh"

module host_access (
	input wire logic                   clock_i,
	input wire logic                   reset_i,
	input wire logic                   start_i,
	input wire eth_mac_pkg::host_op_e  op_i,
	input wire logic [`ETH_ADDR_W-1:0] addr_i,
	input wire logic [7:0]             value_i,
	output logic                       done_o,
	output eth_mac_pkg::host_result_u  return_o,
	ring_if.reader                     rx,
	ring_if.writer                     tx
);

	localparam logic [`ETH_ADDR_W-1:0] PKT_SIZE = `ETH_PACKET_SIZE;

	eth_mac_pkg::host_op_e     op_q;
	eth_mac_pkg::host_result_u result;
	logic                      valid_q;
	logic                      holding_q;   // host sits on the rx reader slot
	logic                      flag_q;
	logic [`ETH_ADDR_W-1:0]    len_q;
	logic                      addr_over;

	assign addr_over = (addr_i >= PKT_SIZE);

	// ----------------------------------------
	// first cycle, ring strobes from the request
	assign rx.rd_addr    = addr_i;
	assign rx.rd_release = start_i && (op_i == eth_mac_pkg::OP_READ_NEXT) && holding_q;
	assign tx.wr_en      = start_i && (op_i == eth_mac_pkg::OP_WRITE) && !addr_over;
	assign tx.wr_addr    = addr_i;
	assign tx.wr_data    = value_i;
	assign tx.commit     = start_i && (op_i == eth_mac_pkg::OP_WRITE_NEXT);
	assign tx.trim       = 1'b0;
	assign tx.clear      = 1'b0;

	always_ff @(posedge clock_i) begin
		if (start_i) begin
			op_q   <= op_i;
			flag_q <= (op_i == eth_mac_pkg::OP_WRITE_NEXT) ? tx.full : addr_over;
			len_q  <= (op_i == eth_mac_pkg::OP_READ_LEN) ? rx.rd_len : tx.wr_len;
		end
		if (valid_q)
			return_o <= result;
	end

	// ----------------------------------------
	// second cycle, return word
	always_comb begin
		result = '0;
		case (op_q)
			eth_mac_pkg::OP_READ:      result.as_byte.data = rx.rd_data;
			eth_mac_pkg::OP_READ_LEN,
			eth_mac_pkg::OP_WRITE_LEN: result.as_len.len = len_q;
			eth_mac_pkg::OP_READ_NEXT: result.as_flag.flag = rx.empty;   // after any release
			default:                   result.as_flag.flag = flag_q;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			valid_q   <= 1'b0;
			done_o    <= 1'b0;
			holding_q <= 1'b0;
		end else begin
			valid_q <= start_i;
			done_o  <= valid_q;
			if (valid_q && op_q == eth_mac_pkg::OP_READ_NEXT)
				holding_q <= !rx.empty;
		end
	end

endmodule

`default_nettype wire

// File: verilog/eth_mac_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_mac_params.svh"

module eth_mac_top (
	input wire logic                   clock_i,
	input wire logic                   reset_i,

	// host port
	input wire logic                   start_i,
	input wire eth_mac_pkg::host_op_e  op_i,
	input wire logic [`ETH_ADDR_W-1:0] addr_i,
	input wire logic [7:0]             value_i,
	output wire                        done_o,
	output eth_mac_pkg::host_result_u  return_o,

	// gmii
	output wire [7:0]                  gmii_txd_o,
	output wire                        gmii_tx_en_o,
	output wire                        gmii_tx_er_o,
	input wire logic [7:0]             gmii_rxd_i,
	input wire logic                   gmii_rx_dv_i,
	input wire logic                   gmii_rx_er_i
);

	ring_if rx_ring ();
	ring_if tx_ring ();

	// ----------------------------------------
	// packet stores
	packet_ring u_rx_ring (
		.clock_i (clock_i),
		.reset_i (reset_i),
		.wr      (rx_ring),
		.rd      (rx_ring)
	);

	packet_ring u_tx_ring (
		.clock_i (clock_i),
		.reset_i (reset_i),
		.wr      (tx_ring),
		.rd      (tx_ring)
	);

	// ----------------------------------------
	// line side
	gmii_rx_deframer u_rx (
		.clock_i      (clock_i),
		.reset_i      (reset_i),
		.gmii_rxd_i   (gmii_rxd_i),
		.gmii_rx_dv_i (gmii_rx_dv_i),
		.gmii_rx_er_i (gmii_rx_er_i),
		.ring         (rx_ring)
	);

	gmii_tx_framer u_tx (
		.clock_i      (clock_i),
		.reset_i      (reset_i),
		.ring         (tx_ring),
		.gmii_txd_o   (gmii_txd_o),
		.gmii_tx_en_o (gmii_tx_en_o),
		.gmii_tx_er_o (gmii_tx_er_o)
	);

	host_access u_host (
		.clock_i  (clock_i),
		.reset_i  (reset_i),
		.start_i  (start_i),
		.op_i     (op_i),
		.addr_i   (addr_i),
		.value_i  (value_i),
		.done_o   (done_o),
		.return_o (return_o),
		.rx       (rx_ring),
		.tx       (tx_ring)
	);

endmodule

`default_nettype wire

// File: tb/tb_eth_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_mac_params.svh"

module tb_eth_mac;

	localparam int MAX_WAIT = 200;

	logic                      clock;
	logic                      reset;
	logic                      start_i;
	eth_mac_pkg::host_op_e     op_i;
	logic [`ETH_ADDR_W-1:0]    addr_i;
	logic [7:0]                value_i;
	wire                       done_o;
	eth_mac_pkg::host_result_u return_o;
	wire [7:0]                 gmii_txd;
	wire                       gmii_tx_en;
	wire                       gmii_tx_er;
	wire [7:0]                 gmii_rxd;
	wire                       gmii_rx_dv;
	wire                       gmii_rx_er;
	logic                      loop_en;   // tx looped back to rx
	logic [7:0]                drv_rxd;
	logic                      drv_rx_dv;
	logic                      drv_rx_er;

	// ----------------------------------------
	// test table
	string       test_name [5] = '{"reset", "tx_frame", "rx_loop", "bad_fcs", "tx_limits"};
	int          test_len  [5] = '{0, 60, 60, 24, 0};
	int          test_seed [5] = '{59, 59, 59, 97, 59};
	logic [15:0] test_exp  [5] = '{16'd1, 16'd0, 16'd0, 16'd1, 16'd1};   // main flag per test

	logic [7:0] payload [$];
	logic [7:0] frame [$];   // preamble to fcs
	logic [7:0] seen [$];
	integer     seed;
	string      cur_name;
	int         test_errors;
	int         errors;
	int         passed;
	bit         hung;

	assign gmii_rxd   = loop_en ? gmii_txd : drv_rxd;
	assign gmii_rx_dv = loop_en ? gmii_tx_en : drv_rx_dv;
	assign gmii_rx_er = loop_en ? gmii_tx_er : drv_rx_er;

	eth_mac_top UUT (
		.clock_i      (clock),
		.reset_i      (reset),
		.start_i      (start_i),
		.op_i         (op_i),
		.addr_i       (addr_i),
		.value_i      (value_i),
		.done_o       (done_o),
		.return_o     (return_o),
		.gmii_txd_o   (gmii_txd),
		.gmii_tx_en_o (gmii_tx_en),
		.gmii_tx_er_o (gmii_tx_er),
		.gmii_rxd_i   (gmii_rxd),
		.gmii_rx_dv_i (gmii_rx_dv),
		.gmii_rx_er_i (gmii_rx_er)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// ieee 802.3 polynomial, register starts at 0, bit 0 first
	function automatic logic [31:0] crc_next(input logic [31:0] crc, input logic [7:0] b);
		logic [31:0] r;
		r = crc;
		for (int k = 0; k < 8; k++)
			r = (r[31] ^ b[k]) ? ({r[30:0], 1'b0} ^ 32'h04C11DB7) : {r[30:0], 1'b0};
		return r;
	endfunction

	function automatic logic [7:0] fcs_byte(input logic [31:0] crc, input int k);
		logic [7:0] b;
		logic [7:0] r;
		b = 8'(crc >> (24 - 8 * k));
		for (int i = 0; i < 8; i++)
			r[i] = ~b[7-i];
		return r;
	endfunction

	task automatic build_frame(input int n, input int seed0);
		logic [31:0] crc;
		seed = seed0;
		payload = {};
		frame = {};
		crc = '0;
		for (int i = 0; i < 7; i++)
			frame.push_back(`ETH_PREAMBLE_BYTE);
		frame.push_back(`ETH_SFD_BYTE);
		for (int i = 0; i < n; i++) begin
			payload.push_back(8'($random(seed)));
			crc = crc_next(crc, payload[i]);
			frame.push_back(payload[i]);
		end
		for (int k = 0; k < 4; k++)
			frame.push_back(fcs_byte(crc, k));
	endtask

	task automatic report_mismatch(input string what, input logic [15:0] exp,
		input logic [15:0] act);
		$display("ERROR %s %s: expected %0h, actual %0h", cur_name, what, exp, act);
		test_errors++;
	endtask

	// ----------------------------------------
	// one host operation, start to done
	task automatic host_op(input eth_mac_pkg::host_op_e op, input int addr,
		input logic [7:0] val, output logic [15:0] res);
		int n;
		@(posedge clock);
		start_i <= 1'b1;
		op_i    <= op;
		addr_i  <= `ETH_ADDR_W'(addr);
		value_i <= val;
		@(posedge clock);
		start_i <= 1'b0;
		n = 0;
		@(negedge clock);
		while (!done_o && n < 8) begin
			@(negedge clock);
			n++;
		end
		if (!done_o) begin
			$display("%s: done_o never came back after start_i", cur_name);
			hung = 1'b1;
			test_errors++;
		end
		res = return_o;
		if (done_o && n != 1) begin
			$display("%s: done_o came %0d cycles after start_i instead of 2", cur_name, n + 1);
			test_errors++;
		end
		@(negedge clock);
		if (done_o !== 1'b0) begin
			$display("%s: done_o stayed high for more than one cycle", cur_name);
			test_errors++;
		end
	endtask

	task automatic capture_frame();
		int n;
		seen = {};
		n = 0;
		while (!gmii_tx_en && n < MAX_WAIT) begin
			@(negedge clock);
			n++;
		end
		if (!gmii_tx_en) begin
			$display("%s: tx_en_o never rose after the packet was committed", cur_name);
			hung = 1'b1;
			test_errors++;
		end
		while (gmii_tx_en && seen.size() < 2 * `ETH_PACKET_SIZE) begin
			if (gmii_tx_er !== 1'b0)
				report_mismatch("tx_er_o", 16'd0, 16'(gmii_tx_er));
			seen.push_back(gmii_txd);
			@(negedge clock);
		end
	endtask

	initial begin
		logic [15:0] ret;
		int          polls;
		reset     <= 1'b1;
		start_i   <= 1'b0;
		op_i      <= eth_mac_pkg::OP_READ;
		addr_i    <= '0;
		value_i   <= 8'd0;
		loop_en   <= 1'b1;
		drv_rxd   <= 8'd0;
		drv_rx_dv <= 1'b0;
		drv_rx_er <= 1'b0;
		errors = 0;
		passed = 0;
		hung = 1'b0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;

		for (int t = 0; t < 5 && !hung; t++) begin
			cur_name = test_name[t];
			test_errors = 0;
			build_frame(test_len[t], test_seed[t]);
			case (t)
				0: begin
					@(negedge clock);
					if (done_o !== 1'b0) report_mismatch("done_o", 16'd0, 16'(done_o));
					if (gmii_tx_en !== 1'b0) report_mismatch("tx_en_o", 16'd0, 16'(gmii_tx_en));
					if (gmii_tx_er !== 1'b0) report_mismatch("tx_er_o", 16'd0, 16'(gmii_tx_er));
					host_op(eth_mac_pkg::OP_READ_NEXT, 0, 8'd0, ret);
					if (ret !== test_exp[t]) report_mismatch("read next", test_exp[t], ret);
				end
				1: begin
					for (int i = 0; i < test_len[t]; i++) begin
						host_op(eth_mac_pkg::OP_WRITE, i, payload[i], ret);
						if (ret !== 16'd0) report_mismatch("write byte", 16'd0, ret);
					end
					host_op(eth_mac_pkg::OP_WRITE_LEN, 0, 8'd0, ret);
					if (ret !== 16'(test_len[t]))
						report_mismatch("write length", 16'(test_len[t]), ret);
					host_op(eth_mac_pkg::OP_WRITE_NEXT, 0, 8'd0, ret);
					if (ret !== test_exp[t]) report_mismatch("write next", test_exp[t], ret);
					capture_frame();
					if (seen.size() != frame.size()) begin
						report_mismatch("tx_en_o cycles", 16'(frame.size()), 16'(seen.size()));
					end else begin
						for (int i = 0; i < frame.size(); i++)
							if (seen[i] !== frame[i])
								report_mismatch($sformatf("frame byte %0d", i),
									16'(frame[i]), 16'(seen[i]));
					end
				end
				2: begin
					polls = 0;
					ret = 16'd1;
					while (ret !== 16'd0 && polls < 20) begin   // wait for the commit
						host_op(eth_mac_pkg::OP_READ_NEXT, 0, 8'd0, ret);
						polls++;
					end
					if (ret !== test_exp[t]) report_mismatch("read next", test_exp[t], ret);
					host_op(eth_mac_pkg::OP_READ_LEN, 0, 8'd0, ret);
					if (ret !== 16'(test_len[t]))
						report_mismatch("read length", 16'(test_len[t]), ret);
					for (int i = 0; i < test_len[t]; i++) begin
						host_op(eth_mac_pkg::OP_READ, i, 8'd0, ret);
						if (ret !== 16'(payload[i]))
							report_mismatch($sformatf("read byte %0d", i), 16'(payload[i]), ret);
					end
					host_op(eth_mac_pkg::OP_READ, test_len[t], 8'd0, ret);
					if (ret !== 16'd0) report_mismatch("read past length", 16'd0, ret);
					host_op(eth_mac_pkg::OP_READ_NEXT, 0, 8'd0, ret);
					if (ret !== 16'd1) report_mismatch("read next at end", 16'd1, ret);
				end
				3: begin
					frame[frame.size() - 3] = frame[frame.size() - 3] ^ 8'h10;   // bad fcs
					@(posedge clock);
					loop_en <= 1'b0;
					for (int i = 0; i < frame.size(); i++) begin
						@(posedge clock);
						drv_rx_dv <= 1'b1;
						drv_rxd   <= frame[i];
					end
					@(posedge clock);
					drv_rx_dv <= 1'b0;
					drv_rxd   <= 8'd0;
					repeat (8) @(posedge clock);   // well past a good frame's commit
					loop_en <= 1'b1;
					host_op(eth_mac_pkg::OP_READ_NEXT, 0, 8'd0, ret);
					if (ret !== test_exp[t]) report_mismatch("read next", test_exp[t], ret);
				end
				default: begin
					host_op(eth_mac_pkg::OP_WRITE, `ETH_PACKET_SIZE, 8'ha5, ret);
					if (ret !== test_exp[t]) report_mismatch("write past end", test_exp[t], ret);
					host_op(eth_mac_pkg::OP_WRITE_NEXT, 0, 8'd0, ret);
					if (ret !== 16'd0) report_mismatch("write next empty", 16'd0, ret);
					polls = 0;
					while (!gmii_tx_en && polls < 40) begin
						@(negedge clock);
						polls++;
					end
					if (gmii_tx_en) begin
						$display("%s: a frame went out for an empty transmit packet", cur_name);
						test_errors++;
					end
				end
			endcase
			if (test_errors == 0) begin
				$display("test %0d %s: ok", t + 1, cur_name);
				passed++;
			end else begin
				$display("test %0d %s: %0d error(s)", t + 1, cur_name, test_errors);
			end
			errors += test_errors;
		end

		$display("tests passed %0d of 5, errors %0d", passed, errors);
		if (errors == 0 && !hung)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: eth_mac.f
+incdir+verilog
verilog/eth_mac_pkg.sv
verilog/ring_if.sv
verilog/packet_ring.sv
verilog/gmii_tx_framer.sv
verilog/gmii_rx_deframer.sv
verilog/host_access.sv
verilog/eth_mac_top.sv
tb/tb_eth_mac.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f eth_mac.f --top-module tb_eth_mac -o sim_eth_mac

out=$(./obj_dir/sim_eth_mac)
echo "$out"

if echo "$out" | grep -qxF "** PASS **"; then
	exit 0
fi
exit 1
